// File: common/nandSccPkg.sv
// NAND SCC shared definitions
// Command field widths, known opcode and target pairs, and the
// primitive bit positions on the primitive-manager buses
package nandSccPkg;

    // Command field widths
    localparam int OpcodeWidth   = 6;
    localparam int TargetIdWidth = 5;

    // Length argument, also the primitive's data count
    localparam int LengthWidth = 16;

    // One-hot primitive command, ready and last-step buses
    localparam int PrimWidth = 8;

    // PHY-interface reset command
    localparam logic [OpcodeWidth-1:0]   OpPiReset     = 6'b110010;
    localparam logic [TargetIdWidth-1:0] TargetPiReset = 5'b00101;

    // Timer command
    localparam logic [OpcodeWidth-1:0]   OpTimer     = 6'b111000;
    localparam logic [TargetIdWidth-1:0] TargetTimer = 5'b00000;

    // Bit positions on the primitive buses
    localparam int PrimBitTimer   = 0;
    localparam int PrimBitPiReset = 4;

endpackage

// File: common/sccCmdIf.sv
// Router to command controller link
// Carries one decoded command and the controller's handshake back
`timescale 1ns/100ps

interface sccCmdIf;
    import nandSccPkg::*;

    // Command valid, driven only toward the addressed controller
    logic                   valid;
    // Controller is idle and can take a command
    logic                   ready;
    // Length argument of the command
    logic [LengthWidth-1:0] length;
    // End of the command's last primitive
    logic                   lastStep;

    modport router (
        output valid,
        output length,
        input  ready,
        input  lastStep
    );

    modport scc (
        input  valid,
        input  length,
        output ready,
        output lastStep
    );

endinterface

// File: common/pmBusIf.sv
// Command controller to arbiter link
// One request port of the shared primitive-manager bus
`timescale 1ns/100ps

interface pmBusIf;
    import nandSccPkg::*;

    // Held high with command and count stable until pmReady
    logic                   request;
    // One-hot primitive command
    logic [PrimWidth-1:0]   pCommand;
    // Data count for the primitive
    logic [LengthWidth-1:0] numOfData;
    // Primitive manager ready, zero unless this port owns the bus
    logic [PrimWidth-1:0]   pmReady;
    // Last-step bus, same on every port
    logic [PrimWidth-1:0]   pmLastStep;

    modport scc (
        output request,
        output pCommand,
        output numOfData,
        input  pmReady,
        input  pmLastStep
    );

    modport arbiter (
        input  request,
        input  pCommand,
        input  numOfData,
        output pmReady,
        output pmLastStep
    );

endinterface

// File: hdl/sccCommandRouter.sv
// Command router
// Decodes opcode and target, steers the command to its controller and
// flags commands that match no controller
`timescale 1ns/100ps

module sccCommandRouter (
    input  logic                                iSystemClock,
    input  logic                                reset,
    input  logic                                iCmdValid,
    output logic                                oCmdReady,
    input  logic [nandSccPkg::OpcodeWidth-1:0]   iOpcode,
    input  logic [nandSccPkg::TargetIdWidth-1:0] iTargetId,
    input  logic [nandSccPkg::LengthWidth-1:0]   iLength,
    output logic                                oCmdLastStep,
    output logic                                oCmdError,
    sccCmdIf.router                             piReset,
    sccCmdIf.router                             timer
);
    import nandSccPkg::*;

    logic matchPiReset;
    logic matchTimer;
    logic unknownCmd;

    // Opcode and target must both match
    assign matchPiReset = (iOpcode == OpPiReset) && (iTargetId == TargetPiReset);
    assign matchTimer   = (iOpcode == OpTimer) && (iTargetId == TargetTimer);
    assign unknownCmd   = !matchPiReset && !matchTimer;

    // Valid goes only to the addressed controller
    assign piReset.valid = iCmdValid && matchPiReset;
    assign timer.valid   = iCmdValid && matchTimer;

    // Length is shared, only the timer makes use of it
    assign piReset.length = iLength;
    assign timer.length   = iLength;

    // Ready follows the addressed controller
    // Unknown commands are always taken
    always_comb begin
        if (matchPiReset) begin
            oCmdReady = piReset.ready;
        end else if (matchTimer) begin
            oCmdReady = timer.ready;
        end else begin
            oCmdReady = 1'b1;
        end
    end

    // Either controller can end a command
    assign oCmdLastStep = piReset.lastStep | timer.lastStep;

    // One-cycle error pulse after an unknown command is consumed
    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            oCmdError <= 1'b0;
        end else begin
            oCmdError <= iCmdValid && unknownCmd;
        end
    end

endmodule

// File: hdl/sccPiReset.sv
// PHY-interface reset controller
// Requests the PI reset primitive, then waits for its last step
`timescale 1ns/100ps

module sccPiReset (
    input  logic iSystemClock,
    input  logic reset,
    sccCmdIf.scc cmd,
    pmBusIf.scc  pm
);
    import nandSccPkg::*;

    typedef enum logic [1:0] {
        Idle,
        Issue,
        Wait
    } stateType;

    stateType rState;
    stateType nextState;
    logic     accepted;

    assign accepted = cmd.valid && cmd.ready;

    // Next state
    always_comb begin
        nextState = rState;
        case (rState)
            Idle: begin
                if (accepted) begin
                    nextState = Issue;
                end
            end
            Issue: begin
                // Any ready bit means the primitive was taken
                if (|pm.pmReady) begin
                    nextState = Wait;
                end
            end
            Wait: begin
                if (pm.pmLastStep[PrimBitPiReset]) begin
                    nextState = Idle;
                end
            end
            default: nextState = Idle;
        endcase
    end

    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            rState <= Idle;
        end else begin
            rState <= nextState;
        end
    end

    // Command handshake
    assign cmd.ready    = (rState == Idle);
    assign cmd.lastStep = (rState == Wait) && pm.pmLastStep[PrimBitPiReset];

    // Primitive request, no data phase
    assign pm.request   = (rState == Issue);
    assign pm.pCommand  = (rState == Issue) ? PrimWidth'(1) << PrimBitPiReset : '0;
    assign pm.numOfData = '0;

endmodule

// File: hdl/sccTimerWait.sv
// Timer-wait controller
// Requests the timer primitive with the command's cycle count, then
// waits for its last step
`timescale 1ns/100ps

module sccTimerWait (
    input  logic iSystemClock,
    input  logic reset,
    sccCmdIf.scc cmd,
    pmBusIf.scc  pm
);
    import nandSccPkg::*;

    typedef enum logic [1:0] {
        Idle,
        Issue,
        Wait
    } stateType;

    stateType               rState;
    stateType               nextState;
    logic                   accepted;
    logic [LengthWidth-1:0] rLength;

    assign accepted = cmd.valid && cmd.ready;

    always_comb begin
        nextState = rState;
        case (rState)
            Idle: begin
                if (accepted) begin
                    nextState = Issue;
                end
            end
            Issue: begin
                if (|pm.pmReady) begin
                    nextState = Wait;
                end
            end
            Wait: begin
                // Timer expiry reported on its own bit
                if (pm.pmLastStep[PrimBitTimer]) begin
                    nextState = Idle;
                end
            end
            default: nextState = Idle;
        endcase
    end

    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            rState <= Idle;
        end else begin
            rState <= nextState;
        end
    end

    // Cycle count captured once per command
    always_ff @(posedge iSystemClock) begin
        if (accepted) begin
            rLength <= cmd.length;
        end
    end

    assign cmd.ready    = (rState == Idle);
    assign cmd.lastStep = (rState == Wait) && pm.pmLastStep[PrimBitTimer];

    // Count stays put for the whole request
    assign pm.request   = (rState == Issue);
    assign pm.pCommand  = (rState == Issue) ? PrimWidth'(1) << PrimBitTimer : '0;
    assign pm.numOfData = rLength;

endmodule

// File: hdl/pmArbiter.sv
// Primitive-manager bus arbiter
// Round-robin grant of the shared bus to one command controller at a time
`timescale 1ns/100ps

module pmArbiter #(
    parameter int NumberOfPorts = 2
) (
    input  logic                              iSystemClock,
    input  logic                              reset,
    pmBusIf.arbiter                           port [NumberOfPorts],
    output logic [nandSccPkg::PrimWidth-1:0]   oPmCommand,
    output logic [nandSccPkg::LengthWidth-1:0] oPmNumOfData,
    input  logic [nandSccPkg::PrimWidth-1:0]   iPmReady,
    input  logic [nandSccPkg::PrimWidth-1:0]   iPmLastStep
);
    import nandSccPkg::*;

    localparam int OwnerWidth = (NumberOfPorts > 1) ? $clog2(NumberOfPorts) : 1;

    logic                   portRequest [NumberOfPorts];
    logic [PrimWidth-1:0]   portCommand [NumberOfPorts];
    logic [LengthWidth-1:0] portCount   [NumberOfPorts];

    logic [OwnerWidth-1:0]  rOwner;
    logic                   rOwnerValid;
    logic [OwnerWidth-1:0]  nextOwner;
    logic                   grantFound;

    // Flatten the interface array so it can be indexed by the owner
    for (genvar g = 0; g < NumberOfPorts; g++) begin : gPort
        assign portRequest[g] = port[g].request;
        assign portCommand[g] = port[g].pCommand;
        assign portCount[g]   = port[g].numOfData;

        // Ready reaches the owner only
        assign port[g].pmReady = (rOwnerValid && (rOwner == OwnerWidth'(g))) ?
                                 iPmReady : '0;
        // Last step goes to everyone, each controller watches its bit
        assign port[g].pmLastStep = iPmLastStep;
    end

    // Round-robin search starting after the last owner
    always_comb begin
        int idx;
        grantFound = 1'b0;
        nextOwner  = rOwner;
        for (int i = 1; i <= NumberOfPorts; i++) begin
            idx = (int'(rOwner) + i) % NumberOfPorts;
            if (!grantFound && portRequest[idx]) begin
                grantFound = 1'b1;
                nextOwner  = OwnerWidth'(idx);
            end
        end
    end

    // Grant drops on the edge the owner's primitive is taken, which is
    // also the edge its request falls
    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            rOwnerValid <= 1'b0;
            rOwner      <= '0;
        end else if (rOwnerValid) begin
            if (|iPmReady) begin
                rOwnerValid <= 1'b0;
            end
        end else if (grantFound) begin
            rOwnerValid <= 1'b1;
            rOwner      <= nextOwner;
        end
    end

    // Owner's primitive out, zeros while the bus is free
    always_comb begin
        if (rOwnerValid) begin
            oPmCommand   = portCommand[rOwner];
            oPmNumOfData = portCount[rOwner];
        end else begin
            oPmCommand   = '0;
            oPmNumOfData = '0;
        end
    end

endmodule

// File: hdl/nandSccTop.sv
// NAND SCC top level
// Command router, PI reset and timer controllers, and the arbiter in
// front of the primitive manager
`timescale 1ns/100ps

module nandSccTop (
    input  logic                                iSystemClock,
    input  logic                                reset,
    // Command port
    input  logic                                iCmdValid,
    output logic                                oCmdReady,
    input  logic [nandSccPkg::OpcodeWidth-1:0]   iOpcode,
    input  logic [nandSccPkg::TargetIdWidth-1:0] iTargetId,
    input  logic [nandSccPkg::LengthWidth-1:0]   iLength,
    output logic                                oCmdLastStep,
    output logic                                oCmdError,
    // Primitive manager port
    output logic [nandSccPkg::PrimWidth-1:0]     oPmCommand,
    output logic [nandSccPkg::LengthWidth-1:0]   oPmNumOfData,
    input  logic [nandSccPkg::PrimWidth-1:0]     iPmReady,
    input  logic [nandSccPkg::PrimWidth-1:0]     iPmLastStep
);

    // One arbiter port per controller
    localparam int NumberOfPorts = 2;

    sccCmdIf piResetCmd ();
    sccCmdIf timerCmd ();

    // Port 0 is PI reset, port 1 is timer
    pmBusIf pmBus [NumberOfPorts] ();

    sccCommandRouter i_router (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .iCmdValid    (iCmdValid),
        .oCmdReady    (oCmdReady),
        .iOpcode      (iOpcode),
        .iTargetId    (iTargetId),
        .iLength      (iLength),
        .oCmdLastStep (oCmdLastStep),
        .oCmdError    (oCmdError),
        .piReset      (piResetCmd),
        .timer        (timerCmd)
    );

    sccPiReset i_piReset (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .cmd          (piResetCmd),
        .pm           (pmBus[0])
    );

    sccTimerWait i_timerWait (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .cmd          (timerCmd),
        .pm           (pmBus[1])
    );

    pmArbiter #(
        .NumberOfPorts (NumberOfPorts)
    ) i_arbiter (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .port         (pmBus),
        .oPmCommand   (oPmCommand),
        .oPmNumOfData (oPmNumOfData),
        .iPmReady     (iPmReady),
        .iPmLastStep  (iPmLastStep)
    );

endmodule

// File: tests/pmArbiter_asserts.sv
// Arbiter bus protocol checks
// One-hot command, hold under back-pressure, ready only at a requesting
// port and a quiet bus right after reset
`timescale 1ns/100ps

module pmArbiterAsserts (
    input logic                                iSystemClock,
    input logic                                reset,
    input logic [nandSccPkg::PrimWidth-1:0]   oPmCommand,
    input logic [nandSccPkg::LengthWidth-1:0] oPmNumOfData,
    input logic [nandSccPkg::PrimWidth-1:0]   iPmReady,
    input logic                                requestPort0,
    input logic                                requestPort1,
    input logic [nandSccPkg::PrimWidth-1:0]   readyPort0,
    input logic [nandSccPkg::PrimWidth-1:0]   readyPort1
);

    // Failed assertions, read back by the testbench
    int failures = 0;

    oneHotCommand: assert property (@(posedge iSystemClock) disable iff (reset)
        $onehot0(oPmCommand))
    else begin
        $error("primitive command has more than one bit set");
        failures++;
    end

    // Primitive stays put until the manager takes it
    holdWhileStalled: assert property (@(posedge iSystemClock) disable iff (reset)
        (oPmCommand != '0 && iPmReady == '0) |=> ($stable(oPmCommand) && $stable(oPmNumOfData)))
    else begin
        $error("primitive changed while the manager withheld ready");
        failures++;
    end

    // A port without a pending request cannot own the bus
    readyOnlyOwner0: assert property (@(posedge iSystemClock) disable iff (reset)
        !requestPort0 |-> readyPort0 == '0)
    else begin
        $error("port 0 saw ready without owning the bus");
        failures++;
    end

    readyOnlyOwner1: assert property (@(posedge iSystemClock) disable iff (reset)
        !requestPort1 |-> readyPort1 == '0)
    else begin
        $error("port 1 saw ready without owning the bus");
        failures++;
    end

    quietAfterReset: assert property (@(posedge iSystemClock)
        reset |=> (oPmCommand == '0 && oPmNumOfData == '0))
    else begin
        $error("primitive bus not idle after reset");
        failures++;
    end

endmodule

bind pmArbiter pmArbiterAsserts i_asserts (
    .iSystemClock (iSystemClock),
    .reset        (reset),
    .oPmCommand   (oPmCommand),
    .oPmNumOfData (oPmNumOfData),
    .iPmReady     (iPmReady),
    .requestPort0 (port[0].request),
    .requestPort1 (port[1].request),
    .readyPort0   (port[0].pmReady),
    .readyPort1   (port[1].pmReady)
);

// File: tests/nandSccTb.sv
// NAND SCC testbench
// Sends commands to the top level, models the primitive manager and
// checks primitives and handshakes against a reference model
`timescale 1ns/100ps

module nandSccTb;
    import nandSccPkg::*;

    localparam int ReadyTimeout  = 300;
    localparam int DrainTimeout  = 600;
    localparam int NumRandomCmds = 200;

    logic                     iSystemClock;
    logic                     reset;
    logic                     iCmdValid;
    logic                     oCmdReady;
    logic [OpcodeWidth-1:0]   iOpcode;
    logic [TargetIdWidth-1:0] iTargetId;
    logic [LengthWidth-1:0]   iLength;
    logic                     oCmdLastStep;
    logic                     oCmdError;
    logic [PrimWidth-1:0]     oPmCommand;
    logic [LengthWidth-1:0]   oPmNumOfData;
    logic [PrimWidth-1:0]     iPmReady;
    logic [PrimWidth-1:0]     iPmLastStep;

    integer seed = 32'h1378;

    // Expected primitives in acceptance order
    logic [PrimWidth-1:0]   expCmdQueue [$];
    logic [LengthWidth-1:0] expCountQueue [$];
    // Controllers holding a command, by primitive bit
    logic [PrimWidth-1:0]   busyBits;
    int acceptedValid  = 0;
    int primitiveCount = 0;
    int lastStepCount  = 0;

    nandSccTop i_dut (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .iCmdValid    (iCmdValid),
        .oCmdReady    (oCmdReady),
        .iOpcode      (iOpcode),
        .iTargetId    (iTargetId),
        .iLength      (iLength),
        .oCmdLastStep (oCmdLastStep),
        .oCmdError    (oCmdError),
        .oPmCommand   (oPmCommand),
        .oPmNumOfData (oPmNumOfData),
        .iPmReady     (iPmReady),
        .iPmLastStep  (iPmLastStep)
    );

    initial iSystemClock = 1'b0;
    always #50 iSystemClock = ~iSystemClock;

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            reportFailure($sformatf("mismatch %s: got 0x%h, expected 0x%h",
                                    name, actual, expected));
        end
    endtask

    function automatic int randomInRange(input int low, input int high);
        randomInRange = low + int'($unsigned($random(seed)) % (high - low + 1));
    endfunction

    // Known pairs map to one primitive, anything else is an error
    function automatic void expectedPrimitive(
        input  logic [OpcodeWidth-1:0]   opcode,
        input  logic [TargetIdWidth-1:0] target,
        input  logic [LengthWidth-1:0]   length,
        output logic [PrimWidth-1:0]     command,
        output logic [LengthWidth-1:0]   count,
        output logic                     isError
    );
        command = '0;
        count   = '0;
        isError = 1'b0;
        if (opcode == OpPiReset && target == TargetPiReset) begin
            command = 8'h10;
        end else if (opcode == OpTimer && target == TargetTimer) begin
            command = 8'h01;
            count   = length;
        end else begin
            isError = 1'b1;
        end
    endfunction

    // Called 10 ns after an edge, returns 10 ns after the accept edge
    task automatic sendCommand(input logic [OpcodeWidth-1:0] opcode,
                               input logic [TargetIdWidth-1:0] target,
                               input logic [LengthWidth-1:0] length);
        int waited;
        waited    = 0;
        iCmdValid = 1'b1;
        iOpcode   = opcode;
        iTargetId = target;
        iLength   = length;
        @(negedge iSystemClock);
        while (!oCmdReady) begin
            waited++;
            if (waited > ReadyTimeout) begin
                reportFailure("timed out waiting for the command port to become ready");
            end
            @(negedge iSystemClock);
        end
        @(posedge iSystemClock);
        #10;
        iCmdValid = 1'b0;
    endtask

    // Until every expected primitive is taken and every controller is done
    task automatic waitForIdle();
        int waited;
        waited = 0;
        @(posedge iSystemClock);
        #10;
        while (expCmdQueue.size() != 0 || busyBits != '0) begin
            waited++;
            if (waited > DrainTimeout) begin
                reportFailure("timed out waiting for outstanding commands to finish");
            end
            @(posedge iSystemClock);
            #10;
        end
    endtask

    // Primitive manager model, samples at the falling edge
    initial begin : pmModel
        logic [PrimWidth-1:0] busCmd;
        logic                 busReset;
        logic                 readyGiven;
        logic                 pulsed;
        int                   readyDelay;
        int                   endDelay;
        int                   lastDelay [PrimWidth];
        iPmReady    = '0;
        iPmLastStep = '0;
        readyGiven  = 1'b0;
        readyDelay  = -1;
        for (int b = 0; b < PrimWidth; b++) begin
            lastDelay[b] = 0;
        end
        forever begin
            @(negedge iSystemClock);
            busCmd   = oPmCommand;
            busReset = reset;
            @(posedge iSystemClock);
            #10;
            iPmReady    = '0;
            iPmLastStep = '0;
            pulsed      = 1'b0;
            if (!busReset) begin
                // One last step per cycle, a second one slips a cycle
                for (int b = 0; b < PrimWidth; b++) begin
                    if (lastDelay[b] > 1 || (lastDelay[b] == 1 && !pulsed)) begin
                        lastDelay[b]--;
                        if (lastDelay[b] == 0) begin
                            iPmLastStep[b] = 1'b1;
                            pulsed         = 1'b1;
                        end
                    end
                end
                if (readyGiven) begin
                    readyGiven = 1'b0;
                end else if (busCmd != '0) begin
                    if (readyDelay < 0) begin
                        readyDelay = randomInRange(0, 3);
                    end
                    if (readyDelay == 0) begin
                        iPmReady   = busCmd;
                        readyGiven = 1'b1;
                        readyDelay = -1;
                        endDelay   = randomInRange(1, 6);
                        for (int b = 0; b < PrimWidth; b++) begin
                            if (busCmd[b]) begin
                                lastDelay[b] = endDelay;
                            end
                        end
                    end else begin
                        readyDelay--;
                    end
                end
            end
        end
    end

    // Compares DUT outputs with the reference at every falling edge
    initial begin : compareProcess
        logic [PrimWidth-1:0]   expCmd;
        logic [LengthWidth-1:0] expCount;
        logic                   expError;
        logic                   expReady;
        logic                   errorDue;
        logic                   heldLast;
        logic [PrimWidth-1:0]   heldCmd;
        logic [LengthWidth-1:0] heldCount;
        errorDue = 1'b0;
        heldLast = 1'b0;
        forever begin
            @(negedge iSystemClock);
            if (reset) begin
                busyBits = '0;
                errorDue = 1'b0;
                heldLast = 1'b0;
            end else begin
                checkValue("oCmdError", oCmdError, errorDue);
                checkValue("oCmdLastStep", oCmdLastStep, |iPmLastStep);
                checkValue("oPmCommand one-hot", $onehot0(oPmCommand), 1);
                // Back-pressure keeps the primitive in place
                if (heldLast) begin
                    checkValue("oPmCommand", oPmCommand, heldCmd);
                    checkValue("oPmNumOfData", oPmNumOfData, heldCount);
                end
                if (iPmReady != '0) begin
                    if (expCmdQueue.size() == 0) begin
                        reportFailure("a primitive was accepted while none was expected");
                    end
                    checkValue("oPmCommand", oPmCommand, expCmdQueue.pop_front());
                    checkValue("oPmNumOfData", oPmNumOfData, expCountQueue.pop_front());
                    primitiveCount++;
                end
                if (oCmdLastStep) begin
                    lastStepCount++;
                end
                errorDue = 1'b0;
                if (iCmdValid) begin
                    expectedPrimitive(iOpcode, iTargetId, iLength, expCmd, expCount, expError);
                    expReady = expError || ((busyBits & expCmd) == '0);
                    checkValue("oCmdReady", oCmdReady, expReady);
                    if (oCmdReady && expError) begin
                        errorDue = 1'b1;
                    end else if (oCmdReady) begin
                        expCmdQueue.push_back(expCmd);
                        expCountQueue.push_back(expCount);
                        busyBits = busyBits | expCmd;
                        acceptedValid++;
                    end
                end
                // Finished controllers are idle from the next cycle
                busyBits  = busyBits & ~iPmLastStep;
                heldLast  = (oPmCommand != '0) && (iPmReady == '0);
                heldCmd   = oPmCommand;
                heldCount = oPmNumOfData;
            end
        end
    end

    initial begin : stimulus
        logic [OpcodeWidth-1:0]   opcode;
        logic [TargetIdWidth-1:0] target;
        int                       kind;
        int                       gap;
        iCmdValid = 1'b0;
        iOpcode   = '0;
        iTargetId = '0;
        iLength   = '0;
        reset     = 1'b1;
        repeat (4) @(posedge iSystemClock);
        #10;
        reset = 1'b0;

        // Quiet outputs right after reset
        @(negedge iSystemClock);
        checkValue("oCmdReady", oCmdReady, 1);
        checkValue("oPmCommand", oPmCommand, 0);
        checkValue("oPmNumOfData", oPmNumOfData, 0);
        checkValue("oCmdLastStep", oCmdLastStep, 0);
        checkValue("oCmdError", oCmdError, 0);
        @(posedge iSystemClock);
        #10;

        // Single PI reset
        sendCommand(OpPiReset, TargetPiReset, 16'h5a5a);
        waitForIdle();
        checkValue("primitive count", primitiveCount, 1);

        // Timers with random lengths, each stalls behind the one before
        for (int i = 0; i < 8; i++) begin
            sendCommand(OpTimer, TargetTimer, 16'($random(seed)));
        end
        waitForIdle();
        checkValue("primitive count", primitiveCount, 9);

        // Crossed and unknown pairs
        sendCommand(OpTimer, TargetPiReset, 16'h0011);
        sendCommand(OpPiReset, TargetTimer, 16'h0022);
        sendCommand(6'h3f, 5'h1f, 16'h0033);
        waitForIdle();
        checkValue("primitive count", primitiveCount, 9);

        // Both controllers in flight, then a PI reset while busy
        sendCommand(OpPiReset, TargetPiReset, 16'h0000);
        sendCommand(OpTimer, TargetTimer, 16'h0100);
        sendCommand(OpPiReset, TargetPiReset, 16'h0000);
        waitForIdle();
        checkValue("primitive count", primitiveCount, 12);

        // Random mix
        for (int i = 0; i < NumRandomCmds; i++) begin
            kind   = randomInRange(0, 3);
            opcode = (kind == 0) ? OpPiReset : OpTimer;
            target = (kind == 0) ? TargetPiReset : TargetTimer;
            if (kind == 3) begin
                opcode = 6'($random(seed));
                target = 5'($random(seed));
            end
            sendCommand(opcode, target, 16'($random(seed)));
            gap = randomInRange(0, 2);
            repeat (gap) begin
                @(posedge iSystemClock);
                #10;
            end
        end
        waitForIdle();
        checkValue("primitive count", primitiveCount, acceptedValid);
        checkValue("last-step pulses", lastStepCount, acceptedValid);

        if (i_dut.i_arbiter.i_asserts.failures == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            reportFailure("bus protocol assertions failed on the arbiter");
        end
    end

endmodule

// File: nandScc.f
common/nandSccPkg.sv
common/sccCmdIf.sv
common/pmBusIf.sv
hdl/sccCommandRouter.sv
hdl/sccPiReset.sv
hdl/sccTimerWait.sv
hdl/pmArbiter.sv
hdl/nandSccTop.sv
tests/pmArbiter_asserts.sv
tests/nandSccTb.sv

// File: runSim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f nandScc.f \
    --top-module nandSccTb -Mdir obj_dir \
    && ./obj_dir/VnandSccTb > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log

cat sim.log
grep -q "Simulation failed" sim.log && exit 1
exit 0
